/* common/emesh_pkg.sv */
/*
   mesh packet layout shared by the transmit path
   field positions are bit indices into the 104-bit packet
   import with a wildcard in the module header
*/
package emesh_pkg;

   //########################################################################
   // packet geometry
   //########################################################################
   localparam int PW     = 104;            // packet width
   localparam int NBYTES = 13;             // bytes per packet on the pins
   localparam int NBW    = $clog2(NBYTES); // byte counter width

   // field positions
   localparam int WRITE_BIT    = 0;        // write/read flag

   localparam int CTRLMODE_LSB = 3;
   localparam int CTRLMODE_MSB = 6;

   localparam int DSTADDR_LSB  = 8;        // 32-bit destination address
   localparam int DSTADDR_MSB  = 39;

   // chip id is the top 12 bits of dstaddr
   localparam int CHIPID_LSB   = 28;
   localparam int CHIPID_MSB   = 39;

   //########################################################################
   // chip ids
   //########################################################################
   localparam logic [11:0] ID       = 12'd999; // own id, local traffic
   localparam logic [11:0] REMAP_ID = 12'h810; // id forced in by remap

endpackage

/* common/etx_regmap_pkg.sv */
/*
   register map of the tx configuration block
   word indices, config field and status bit positions
   mi_addr is a byte address, index taken from bits RFAW+1:2
*/
package etx_regmap_pkg;

   localparam int RFAW = 6;                  // word address width

   // register word indices
   localparam logic [RFAW-1:0] E_VERSION   = 6'd0;
   localparam logic [RFAW-1:0] ETX_CFG     = 6'd1;
   localparam logic [RFAW-1:0] ETX_STATUS  = 6'd2;
   localparam logic [RFAW-1:0] ETX_GPIO    = 6'd3;
   localparam logic [RFAW-1:0] ETX_MONITOR = 6'd4;
   localparam logic [RFAW-1:0] ETX_PACKET  = 6'd5;

   localparam logic [15:0] DEFAULT_VERSION = 16'h0102;

   //########################################################################
   // config fields
   //########################################################################
   localparam int CFG_W         = 12;     // config register width
   localparam int CFG_TX_EN     = 0;
   localparam int CFG_MMU_EN    = 1;
   localparam int CFG_REMAP_LSB = 2;      // 2'b01 turns remap on
   localparam int CFG_REMAP_MSB = 3;
   localparam int CFG_CTRL_LSB  = 4;      // ctrlmode value
   localparam int CFG_CTRL_MSB  = 7;
   localparam int CFG_BYPASS    = 8;
   localparam int CFG_GPIO_LSB  = 9;      // 2'b01 selects gpio pins
   localparam int CFG_GPIO_MSB  = 10;
   localparam int CFG_BURST     = 11;

   // status bits
   localparam int ST_SENT = 0;            // last byte went out
   localparam int ST_DROP = 1;            // access refused
   localparam int ST_GPIO = 6;            // gpio mode level
   localparam int ST_OFF  = 7;            // tx disabled level

endpackage

/* etx_cfg/etx_cfg.sv */
/*
   tx configuration register file on the mi bus
   holds version, config, status, gpio, monitor and packet sampler
   reads are pipelined, data valid one cycle after the strobe
*/
module etx_cfg
   import emesh_pkg::*, etx_regmap_pkg::*;
(
   input  logic            clk,
   input  logic            nreset,
   // mi bus
   input  logic            mi_en,
   input  logic            mi_we,
   input  logic [RFAW+1:0] mi_addr,          // byte address
   input  logic [31:0]     mi_din,
   output logic [31:0]     mi_dout,
   // observed tx traffic
   input  logic [15:0]     tx_status,
   input  logic            etx_access,
   input  logic [PW-1:0]   etx_packet,
   // decoded config
   output logic            tx_enable,
   output logic            mmu_enable,
   output logic            gpio_enable,
   output logic            remap_enable,
   output logic            burst_enable,
   output logic [3:0]      ctrlmode,
   output logic            ctrlmode_bypass,
   output logic [8:0]      gpio_data
);

   logic [15:0]      version_reg;
   logic [CFG_W-1:0] cfg_reg;
   logic [15:0]      status_reg;
   logic [8:0]       gpio_reg;
   logic [31:0]      monitor_reg;
   logic [31:0]      packet_reg;

   logic [RFAW-1:0]  reg_idx;
   logic             cfg_wr_strobe;
   logic             cfg_rd_strobe;
   logic             version_write;
   logic             config_write;
   logic             status_write;
   logic             gpio_write;
   logic             monitor_write;
   logic             remote_pkt;               // counted and sampled

   //########################################################################
   // address decode
   //########################################################################
   assign reg_idx       = mi_addr[RFAW+1:2];   // drop byte offset
   assign cfg_wr_strobe = mi_en & mi_we;
   assign cfg_rd_strobe = mi_en & ~mi_we;

   assign version_write = cfg_wr_strobe & (reg_idx == E_VERSION);
   assign config_write  = cfg_wr_strobe & (reg_idx == ETX_CFG);
   assign status_write  = cfg_wr_strobe & (reg_idx == ETX_STATUS);
   assign gpio_write    = cfg_wr_strobe & (reg_idx == ETX_GPIO);
   assign monitor_write = cfg_wr_strobe & (reg_idx == ETX_MONITOR);

   // version, reset to the build value
   always_ff @(posedge clk) begin
      if (!nreset)
         version_reg <= DEFAULT_VERSION;
      else if (version_write)
         version_reg <= mi_din[15:0];
   end

   // config, everything off after reset
   always_ff @(posedge clk) begin
      if (!nreset)
         cfg_reg <= '0;
      else if (config_write)
         cfg_reg <= mi_din[CFG_W-1:0];
   end

   assign tx_enable       = cfg_reg[CFG_TX_EN];
   assign mmu_enable      = cfg_reg[CFG_MMU_EN];
   assign remap_enable    = (cfg_reg[CFG_REMAP_MSB:CFG_REMAP_LSB] == 2'b01);
   assign ctrlmode        = cfg_reg[CFG_CTRL_MSB:CFG_CTRL_LSB];
   assign ctrlmode_bypass = cfg_reg[CFG_BYPASS];
   assign gpio_enable     = (cfg_reg[CFG_GPIO_MSB:CFG_GPIO_LSB] == 2'b01);
   assign burst_enable    = cfg_reg[CFG_BURST];

   // sticky status, a write clears or presets it
   always_ff @(posedge clk) begin
      if (!nreset)
         status_reg <= '0;
      else if (status_write)
         status_reg <= mi_din[15:0];
      else
         status_reg <= status_reg | tx_status;   // accumulate events
   end

   // static pin values for gpio mode
   always_ff @(posedge clk) begin
      if (!nreset)
         gpio_reg <= '0;
      else if (gpio_write)
         gpio_reg <= mi_din[8:0];
   end

   assign gpio_data = gpio_reg;

   //########################################################################
   // transaction monitor and sampler
   //########################################################################
   // remote traffic only, and only while the pins are in serial mode
   assign remote_pkt = etx_access
                     & (etx_packet[CHIPID_MSB:CHIPID_LSB] != ID)
                     & ~tx_status[ST_OFF]
                     & ~tx_status[ST_GPIO];

   always_ff @(posedge clk) begin
      if (!nreset)
         monitor_reg <= '0;
      else if (monitor_write)
         monitor_reg <= mi_din;
      else if (remote_pkt)
         monitor_reg <= monitor_reg + 32'd1;
   end

   always_ff @(posedge clk) begin
      if (!nreset)
         packet_reg <= '0;
      else if (remote_pkt)
         packet_reg <= etx_packet[DSTADDR_MSB:DSTADDR_LSB];   // last dstaddr
   end

   //########################################################################
   // readback, one cycle latency, zero when idle
   //########################################################################
   always_ff @(posedge clk) begin
      if (!nreset)
         mi_dout <= '0;
      else if (cfg_rd_strobe) begin
         case (reg_idx)
            E_VERSION:   mi_dout <= {16'b0, version_reg};
            ETX_CFG:     mi_dout <= {{(32-CFG_W){1'b0}}, cfg_reg};
            ETX_STATUS:  mi_dout <= {16'b0, status_reg};
            ETX_GPIO:    mi_dout <= {23'b0, gpio_reg};
            ETX_MONITOR: mi_dout <= monitor_reg;
            ETX_PACKET:  mi_dout <= packet_reg;
            default:     mi_dout <= '0;            // unmapped
         endcase
      end
      else
         mi_dout <= '0;
   end

endmodule

/* design/etx_remap.sv */
/*
   one-cycle remap stage in front of the serializer
   optionally forces the chip-id and ctrlmode fields of the packet
*/
module etx_remap
   import emesh_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          access_in,
   input  logic [PW-1:0] packet_in,
   input  logic          remap_enable,      // force chip id to REMAP_ID
   input  logic [3:0]    ctrlmode,
   input  logic          ctrlmode_bypass,   // force ctrlmode field
   output logic          remap_access,
   output logic [PW-1:0] remap_packet
);

   logic [PW-1:0] packet_mod;

   //########################################################################
   // field rewrite, ahead of the register
   //########################################################################
   always_comb begin
      packet_mod = packet_in;
      if (remap_enable)
         packet_mod[CHIPID_MSB:CHIPID_LSB] = REMAP_ID;     // upper dstaddr
      if (ctrlmode_bypass)
         packet_mod[CTRLMODE_MSB:CTRLMODE_LSB] = ctrlmode;
   end

   // strobe, cleared on reset
   always_ff @(posedge clk) begin
      if (!nreset)
         remap_access <= 1'b0;
      else
         remap_access <= access_in;
   end

   // payload, loaded only with a strobe
   always_ff @(posedge clk) begin
      if (access_in)
         remap_packet <= packet_mod;
   end

endmodule

/* design/etx_serializer.sv */
/*
   byte serializer and pin mux for the tx link
   one frame pin plus eight data pins, 13 bytes per packet, lsb byte first
   pins carry gpio values in gpio mode and stay low while tx is off
*/
module etx_serializer
   import emesh_pkg::*, etx_regmap_pkg::*;
(
   input  logic          clk,
   input  logic          nreset,
   input  logic          access,
   input  logic [PW-1:0] packet,
   input  logic          tx_enable,
   input  logic          gpio_enable,
   input  logic [8:0]    gpio_data,     // bit 8 frame, 7:0 data
   output logic          txo_frame,
   output logic [7:0]    txo_data,
   output logic          busy,
   output logic [15:0]   tx_status
);

   logic [PW-1:0]  shift_q;            // remaining bytes, low byte on pins
   logic [NBW-1:0] byte_cnt;
   logic           accept;
   logic           last_byte;

   // only take a packet in serial mode and when idle
   assign accept    = access & tx_enable & ~gpio_enable & ~busy;
   assign last_byte = busy & (byte_cnt == NBW'(NBYTES - 1));

   //########################################################################
   // packet sequencing
   //########################################################################
   always_ff @(posedge clk) begin
      if (!nreset) begin
         busy     <= 1'b0;
         byte_cnt <= '0;
      end
      else if (accept) begin
         busy     <= 1'b1;
         byte_cnt <= '0;
      end
      else if (busy) begin
         byte_cnt <= byte_cnt + 1'b1;
         if (last_byte)
            busy <= 1'b0;       // frame ends after byte 12
      end
   end

   always_ff @(posedge clk) begin
      if (accept)
         shift_q <= packet;
      else if (busy)
         shift_q <= {8'b0, shift_q[PW-1:8]};    // next byte down
   end

   //########################################################################
   // pin mux
   //########################################################################
   always_comb begin
      if (!tx_enable) begin
         txo_frame = 1'b0;                      // link quiet
         txo_data  = 8'b0;
      end
      else if (gpio_enable) begin
         txo_frame = gpio_data[8];
         txo_data  = gpio_data[7:0];
      end
      else begin
         txo_frame = busy;
         txo_data  = busy ? shift_q[7:0] : 8'b0;
      end
   end

   // event pulses and mode levels for the status register
   always_comb begin
      tx_status          = '0;
      tx_status[ST_SENT] = last_byte;
      tx_status[ST_DROP] = access & ~accept;   // busy, off or gpio
      tx_status[ST_GPIO] = gpio_enable;
      tx_status[ST_OFF]  = ~tx_enable;
   end

endmodule

/* design/etx_top.sv */
/*
   transmit side of the chip link
   remap stage, byte serializer and mi config registers
   packets enter as a strobe, first byte on the pins 2 cycles later
*/
module etx_top
   import emesh_pkg::*, etx_regmap_pkg::*;
(
   input  logic            clk,
   input  logic            nreset,
   // mi bus
   input  logic            mi_en,
   input  logic            mi_we,
   input  logic [RFAW+1:0] mi_addr,
   input  logic [31:0]     mi_din,
   output logic [31:0]     mi_dout,
   // packet in
   input  logic            access_in,
   input  logic [PW-1:0]   packet_in,
   output logic            busy,
   // pins
   output logic            txo_frame,
   output logic [7:0]      txo_data,
   // config only exported
   output logic            mmu_enable,
   output logic            burst_enable
);

   logic          remap_access;
   logic [PW-1:0] remap_packet;
   logic          tx_enable;
   logic          gpio_enable;
   logic          remap_enable;
   logic [3:0]    ctrlmode;
   logic          ctrlmode_bypass;
   logic [8:0]    gpio_data;
   logic [15:0]   tx_status;

   etx_remap i_etx_remap (
      .clk             (clk),
      .nreset          (nreset),
      .access_in       (access_in),
      .packet_in       (packet_in),
      .remap_enable    (remap_enable),
      .ctrlmode        (ctrlmode),
      .ctrlmode_bypass (ctrlmode_bypass),
      .remap_access    (remap_access),
      .remap_packet    (remap_packet)
   );

   etx_serializer i_etx_serializer (
      .clk         (clk),
      .nreset      (nreset),
      .access      (remap_access),
      .packet      (remap_packet),
      .tx_enable   (tx_enable),
      .gpio_enable (gpio_enable),
      .gpio_data   (gpio_data),
      .txo_frame   (txo_frame),
      .txo_data    (txo_data),
      .busy        (busy),
      .tx_status   (tx_status)
   );

   // monitor sees the remapped traffic as it reaches the pins
   etx_cfg i_etx_cfg (
      .clk             (clk),
      .nreset          (nreset),
      .mi_en           (mi_en),
      .mi_we           (mi_we),
      .mi_addr         (mi_addr),
      .mi_din          (mi_din),
      .mi_dout         (mi_dout),
      .tx_status       (tx_status),
      .etx_access      (remap_access),
      .etx_packet      (remap_packet),
      .tx_enable       (tx_enable),
      .mmu_enable      (mmu_enable),
      .gpio_enable     (gpio_enable),
      .remap_enable    (remap_enable),
      .burst_enable    (burst_enable),
      .ctrlmode        (ctrlmode),
      .ctrlmode_bypass (ctrlmode_bypass),
      .gpio_data       (gpio_data)
   );

endmodule

/* sim/tb_etx_top.sv */
/*
   testbench for the tx link top level
   random mi and packet traffic from a fixed seed, inputs change on falling edges
   a cycle model of registers, remap stage and pins is compared every cycle
*/
module tb_etx_top
   import emesh_pkg::*, etx_regmap_pkg::*;
();

   localparam int N_CYCLES = 1400;                  // random traffic phase
   localparam int LIMIT    = 4 * (N_CYCLES + 60);   // setup and directed cycles

   logic            clk;
   logic            nreset;
   logic            mi_en;
   logic            mi_we;
   logic [RFAW+1:0] mi_addr;
   logic [31:0]     mi_din;
   logic [31:0]     mi_dout;
   logic            access_in;
   logic [PW-1:0]   packet_in;
   logic            busy;
   logic            txo_frame;
   logic [7:0]      txo_data;
   logic            mmu_enable;
   logic            burst_enable;

   // model state, as it should look after each rising edge
   logic [15:0]      m_version;
   logic [CFG_W-1:0] m_cfg;
   logic [15:0]      m_status;
   logic [8:0]       m_gpio;
   logic [31:0]      m_monitor;
   logic [31:0]      m_packet;
   logic [31:0]      m_dout;
   logic             m_racc;                       // remap stage strobe
   logic [PW-1:0]    m_rpkt;
   logic [7:0]       byte_q[$];                    // bytes still to appear

   // register lists for the directed and random phases
   logic [RFAW-1:0] idx_list[4]   = '{E_VERSION, ETX_STATUS, ETX_GPIO, ETX_MONITOR};
   logic [RFAW-1:0] wr_list[4]    = '{E_VERSION, ETX_STATUS, ETX_GPIO, ETX_MONITOR};
   logic [RFAW-1:0] final_list[4] = '{ETX_CFG, ETX_STATUS, ETX_MONITOR, ETX_PACKET};

   integer seed;
   int     checks;
   int     errors;
   int     sent_cnt;
   int     drop_cnt;
   int     cycle_cnt = 0;

   etx_top i_etx_top (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // runaway guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("TB FAILED");
         $finish;
      end
   end

   //########################################################################
   // reference rules
   //########################################################################
   function automatic logic [PW-1:0] remap_rule(input logic [PW-1:0] pkt,
                                                input logic [CFG_W-1:0] cfg);
      logic [PW-1:0] p;
      p = pkt;
      if (cfg[CFG_REMAP_MSB:CFG_REMAP_LSB] == 2'b01)
         p[CHIPID_MSB:CHIPID_LSB] = REMAP_ID;          // chip id forced
      if (cfg[CFG_BYPASS])
         p[CTRLMODE_MSB:CTRLMODE_LSB] = cfg[CFG_CTRL_MSB:CFG_CTRL_LSB];
      return p;
   endfunction

   function automatic logic [31:0] read_value(input logic [RFAW-1:0] idx);
      case (idx)
         E_VERSION:   return {16'b0, m_version};
         ETX_CFG:     return {20'b0, m_cfg};
         ETX_STATUS:  return {16'b0, m_status};
         ETX_GPIO:    return {23'b0, m_gpio};
         ETX_MONITOR: return m_monitor;
         ETX_PACKET:  return m_packet;
         default:     return 32'b0;                   // hole in the map
      endcase
   endfunction

   // advance the model by one clock with the inputs now driven
   task automatic model_step;
      logic [RFAW-1:0] idx;
      logic            tx_on;
      logic            gpio_on;
      logic            accept;
      logic            remote;
      logic [15:0]     events;
      idx     = mi_addr[RFAW+1:2];
      tx_on   = m_cfg[CFG_TX_EN];
      gpio_on = (m_cfg[CFG_GPIO_MSB:CFG_GPIO_LSB] == 2'b01);
      accept  = m_racc & tx_on & ~gpio_on & (byte_q.size() == 0);
      remote  = m_racc & (m_rpkt[CHIPID_MSB:CHIPID_LSB] != ID) & tx_on & ~gpio_on;
      events          = '0;
      events[ST_SENT] = (byte_q.size() == 1);        // last byte on the pins
      events[ST_DROP] = m_racc & ~accept;
      events[ST_GPIO] = gpio_on;
      events[ST_OFF]  = ~tx_on;
      if (events[ST_SENT])
         sent_cnt++;
      if (events[ST_DROP])
         drop_cnt++;
      m_dout = (mi_en && !mi_we) ? read_value(idx) : 32'b0;
      if (remote)
         m_packet = m_rpkt[DSTADDR_MSB:DSTADDR_LSB];
      if (accept) begin
         for (int k = 0; k < NBYTES; k++)
            byte_q.push_back(m_rpkt[8*k +: 8]);      // low byte first
      end
      else if (byte_q.size() != 0)
         void'(byte_q.pop_front());
      // remap uses the config seen in the cycle of access_in
      m_racc = access_in;
      if (access_in)
         m_rpkt = remap_rule(packet_in, m_cfg);
      m_status = m_status | events;
      if (remote)
         m_monitor = m_monitor + 32'd1;
      if (mi_en && mi_we) begin
         case (idx)
            E_VERSION:   m_version = mi_din[15:0];
            ETX_CFG:     m_cfg     = mi_din[CFG_W-1:0];
            ETX_STATUS:  m_status  = mi_din[15:0];
            ETX_GPIO:    m_gpio    = mi_din[8:0];
            ETX_MONITOR: m_monitor = mi_din;
            default:     ;
         endcase
      end
   endtask

   //########################################################################
   // checks
   //########################################################################
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_outputs;
      logic       exp_busy;
      logic       exp_frame;
      logic [7:0] exp_data;
      exp_busy = (byte_q.size() != 0);
      if (!m_cfg[CFG_TX_EN]) begin
         exp_frame = 1'b0;                           // pins quiet
         exp_data  = 8'b0;
      end
      else if (m_cfg[CFG_GPIO_MSB:CFG_GPIO_LSB] == 2'b01) begin
         exp_frame = m_gpio[8];
         exp_data  = m_gpio[7:0];
      end
      else begin
         exp_frame = exp_busy;
         exp_data  = exp_busy ? byte_q[0] : 8'b0;
      end
      check_value("txo_frame", 32'(exp_frame), 32'(txo_frame));
      check_value("txo_data", 32'(exp_data), 32'(txo_data));
      check_value("busy", 32'(exp_busy), 32'(busy));
      check_value("mi_dout", m_dout, mi_dout);
      check_value("mmu_enable", 32'(m_cfg[CFG_MMU_EN]), 32'(mmu_enable));
      check_value("burst_enable", 32'(m_cfg[CFG_BURST]), 32'(burst_enable));
   endtask

   task automatic cycle;
      model_step();
      @(posedge clk);
      @(negedge clk);                                // outputs settled here
      check_outputs();
      mi_en     = 1'b0;
      mi_we     = 1'b0;
      access_in = 1'b0;
   endtask

   //########################################################################
   // stimulus helpers
   //########################################################################
   task automatic drive_write(input logic [RFAW-1:0] idx, input logic [31:0] data);
      logic [31:0] r;
      r       = $random(seed);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = {idx, r[1:0]};                       // byte offset ignored
      mi_din  = data;
   endtask

   task automatic drive_read(input logic [RFAW-1:0] idx);
      logic [31:0] r;
      r       = $random(seed);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = {idx, r[1:0]};
      mi_din  = r;                                   // don't care on reads
   endtask

   task automatic random_packet(output logic [PW-1:0] pkt);
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      r0  = $random(seed);
      r1  = $random(seed);
      r2  = $random(seed);
      r3  = $random(seed);
      pkt = {r3[7:0], r2, r1, r0};
      if (r3[15:8] < 8'd85)
         pkt[CHIPID_MSB:CHIPID_LSB] = ID;            // about a third local
   endtask

   task automatic random_cfg(output logic [CFG_W-1:0] cfg);
      logic [31:0] r;
      r   = $random(seed);
      cfg = r[CFG_W-1:0];
      case (r[14:12])
         3'd0: cfg[CFG_TX_EN] = 1'b0;                // link off
         3'd1: begin
            cfg[CFG_TX_EN]                   = 1'b1;
            cfg[CFG_GPIO_MSB:CFG_GPIO_LSB] = 2'b01;
         end
         default: begin                              // serial mode mostly
            cfg[CFG_TX_EN] = 1'b1;
            if (cfg[CFG_GPIO_MSB:CFG_GPIO_LSB] == 2'b01)
               cfg[CFG_GPIO_MSB:CFG_GPIO_LSB] = 2'b10;
         end
      endcase
   endtask

   //########################################################################
   // main sequence
   //########################################################################
   initial begin
      logic [31:0]      r;
      logic [CFG_W-1:0] cfg;
      logic [PW-1:0]    pkt;
      logic [RFAW-1:0]  idx;
      seed      = 32'hed6cb80a;
      checks    = 0;
      errors    = 0;
      sent_cnt  = 0;
      drop_cnt  = 0;
      nreset    = 1'b0;
      mi_en     = 1'b0;
      mi_we     = 1'b0;
      mi_addr   = '0;
      mi_din    = '0;
      access_in = 1'b0;
      packet_in = '0;
      m_version = DEFAULT_VERSION;
      m_cfg     = '0;
      m_status  = '0;
      m_gpio    = '0;
      m_monitor = '0;
      m_packet  = '0;
      m_dout    = '0;
      m_racc    = 1'b0;
      m_rpkt    = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_outputs();                               // reset values
      nreset = 1'b1;

      // reset readback incl. unmapped words
      for (int k = 0; k < 8; k++) begin
         drive_read(RFAW'(k));
         cycle();
      end
      drive_read(6'd40);
      cycle();
      cycle();

      // write then read back, widths masked
      foreach (idx_list[k]) begin
         r = $random(seed);
         drive_write(idx_list[k], r);
         cycle();
         drive_read(idx_list[k]);
         cycle();
      end

      // plain serial path first, then random config every 200 cycles
      drive_write(ETX_CFG, 32'h1);
      cycle();
      for (int i = 0; i < N_CYCLES; i++) begin
         r = $random(seed);
         if (i % 200 == 100) begin
            random_cfg(cfg);
            drive_write(ETX_CFG, {20'b0, cfg});
         end
         else if (r[3:0] < 4'd3) begin
            idx = (r[12:10] == 3'd0) ? r[21:16] : {3'b0, r[6:4]};
            drive_read(idx);
         end
         else if (r[3:0] == 4'd3)
            drive_write(wr_list[r[5:4]], $random(seed));
         // offers while busy are rarer, frames are 13 cycles long
         if ((byte_q.size() == 0 && r[9:8] == 2'd0) ||
             (byte_q.size() != 0 && r[30:25] < 6'd3)) begin
            random_packet(pkt);
            access_in = 1'b1;
            packet_in = pkt;
         end
         cycle();
      end

      // gpio pins, then link off with the exported bits set
      drive_write(ETX_GPIO, 32'h1a5);
      cycle();
      drive_write(ETX_CFG, 32'h203);
      cycle();
      cycle();
      drive_write(ETX_CFG, 32'h802);
      cycle();
      random_packet(pkt);
      access_in = 1'b1;
      packet_in = pkt;
      cycle();
      repeat (3) cycle();
      foreach (final_list[k]) begin
         drive_read(final_list[k]);
         cycle();
      end
      cycle();

      if (sent_cnt == 0 || drop_cnt == 0) begin
         errors++;
         $display("no sent or no dropped packet seen, traffic did not reach the pins");
      end
      $display("%0d checks, %0d errors, %0d packets sent, %0d dropped",
               checks, errors, sent_cnt, drop_cnt);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

/* etx_link.f */
common/emesh_pkg.sv
common/etx_regmap_pkg.sv
etx_cfg/etx_cfg.sv
design/etx_remap.sv
design/etx_serializer.sv
design/etx_top.sv
sim/tb_etx_top.sv

/* run_sim.sh */
#!/bin/sh
# build the tx link testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_etx_top -f etx_link.f -o tb_etx_top

out=$(./obj_dir/tb_etx_top)
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
   exit 0
fi
exit 1
